/* Makefile */
SIM      := verilator
TOP      := dual_cam_line_tb
FILELIST := dual_cam_line_top.f
FLAGS    := --binary --timing --assert
OBJ_DIR  := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass line"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf $(OBJ_DIR)

/* bench/dual_cam_line_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module dual_cam_line_asserts (
    input wire                            rclk,
    input wire                            rstn,
    input wire cam_line_pkg::swap_state_t state,
    input wire                            cam1_trig,
    input wire                            cam1_busy,
    input wire                            cam2_trig,
    input wire                            cam2_busy,
    input wire                            out_valid,
    input wire                            out_ready,
    input wire [15:0]                     out_pixel,
    input wire [10:0]                     out_row,
    input wire cam_line_pkg::cam_id_t     out_id,
    input wire                            out_last
);

    import cam_line_pkg::*;

    // ~~~~~~~~~~~~~~~~~~~~
    // Trigger / busy
    // ~~~~~~~~~~~~~~~~~~~~
    trig1_until_busy: assert property (@(posedge rclk) disable iff (!rstn)
        $fell(cam1_trig) |-> $past(cam1_busy))
        else $error("cam1 trig dropped before busy rose");

    trig2_until_busy: assert property (@(posedge rclk) disable iff (!rstn)
        $fell(cam2_trig) |-> $past(cam2_busy))
        else $error("cam2 trig dropped before busy rose");

    one_busy_in_trig_cam2: assert property (@(posedge rclk) disable iff (!rstn)
        (state == trig_cam2) |-> !(cam1_busy && cam2_busy))
        else $error("both line buffers busy in trig_cam2");

    // Output beat frozen while stalled
    out_held: assert property (@(posedge rclk) disable iff (!rstn)
        (out_valid && !out_ready) |=>
            (out_valid && $stable({out_pixel, out_row, out_id, out_last})))
        else $error("output beat changed or vanished before transfer");

endmodule : dual_cam_line_asserts

bind dual_cam_line_top dual_cam_line_asserts u_asserts (
    .rclk     (rclk),
    .rstn     (rstn),
    .state    (u_swap.state),
    .cam1_trig(u_swap.cam1_trig),
    .cam1_busy(u_swap.cam1_busy),
    .cam2_trig(u_swap.cam2_trig),
    .cam2_busy(u_swap.cam2_busy),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .out_pixel(out_pixel),
    .out_row  (out_row),
    .out_id   (out_id),
    .out_last (out_last)
);

`default_nettype wire

/* bench/dual_cam_line_checker.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cam_line_config.svh"

module dual_cam_line_checker #(
    parameter int H_ACT = 8
) (
    input  wire                        rclk,
    input  wire                        rstn,
    input  wire                        out_valid,
    input  wire                        out_ready,
    input  wire [15:0]                 out_pixel,
    input  wire [10:0]                 out_row,
    input  wire cam_line_pkg::cam_id_t out_id,
    input  wire                        out_last,
    input  wire                        error,
    input  wire                        test_start,
    input  wire                        test_end,
    input  int                         test_num,
    input  int                         exp_lines,
    input  wire                        exp_err,
    output int                         lines_seen,
    output int                         beats_seen,
    output int                         tests_run,
    output int                         tests_failed,
    output int                         fail_cnt
);

    import cam_line_pkg::*;

    int          pix_idx;       // Beat index inside the current line
    int          test_errs;
    logic [10:0] line_row;
    logic        stall;
    logic [15:0] hold_pixel;
    logic [10:0] hold_row;
    cam_id_t     hold_id;
    logic        hold_last;

    function automatic logic [3:0] cam_number(input cam_id_t id);
        if (id == `CAM1_ID) begin
            return 4'd1;
        end
        if (id == `CAM2_ID) begin
            return 4'd2;
        end
        return 4'hf;
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED test %0d beat %0d: %s = %h, expected %h",
                     test_num, beats_seen, name, got, exp);
            test_errs++;
            fail_cnt++;
        end
    endtask

    task automatic check_beat();
        cam_id_t     exp_id;
        logic [15:0] exp_pixel;
        exp_id = (lines_seen % 2 == 0) ? `CAM1_ID : `CAM2_ID;   // Camera 1 first
        compare("out_id", 32'(out_id), 32'(exp_id));
        if (pix_idx == 0) begin
            line_row = out_row;
        end else begin
            compare("out_row", 32'(out_row), 32'(line_row));
        end
        exp_pixel = {cam_number(out_id), out_row[3:0], 8'(pix_idx)};
        compare("out_pixel", 32'(out_pixel), 32'(exp_pixel));
        compare("out_last", 32'(out_last), 32'(pix_idx == H_ACT - 1));
        beats_seen++;
        if (pix_idx == H_ACT - 1) begin
            pix_idx = 0;
            lines_seen++;
        end else begin
            pix_idx++;
        end
    endtask

    task automatic finish_test();
        if (lines_seen != exp_lines) begin
            $display("test %0d: %0d lines arrived where %0d were expected",
                     test_num, lines_seen, exp_lines);
            test_errs++;
            fail_cnt++;
        end
        if (pix_idx != 0) begin
            $display("test %0d: last line stopped after %0d beats", test_num, pix_idx);
            test_errs++;
            fail_cnt++;
        end
        compare("error", 32'(error), 32'(exp_err));
        tests_run++;
        if (test_errs == 0) begin
            $display("test %0d: %0d lines, %0d beats, ok", test_num, lines_seen, beats_seen);
        end else begin
            tests_failed++;
            $display("test %0d: %0d lines, %0d beats, %0d errors",
                     test_num, lines_seen, beats_seen, test_errs);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Output monitor
    // ~~~~~~~~~~~~~~~~~~~~
    always @(posedge rclk) begin
        if (!rstn) begin
            stall   = 1'b0;
            pix_idx = 0;
        end else begin
            if (test_start) begin
                lines_seen = 0;
                beats_seen = 0;
                pix_idx    = 0;
                test_errs  = 0;
            end
            if (stall) begin
                if (!out_valid) begin
                    $display("test %0d: out_valid dropped before the beat was taken", test_num);
                    test_errs++;
                    fail_cnt++;
                end else begin
                    compare("out_pixel", 32'(out_pixel), 32'(hold_pixel));
                    compare("out_row", 32'(out_row), 32'(hold_row));
                    compare("out_id", 32'(out_id), 32'(hold_id));
                    compare("out_last", 32'(out_last), 32'(hold_last));
                end
            end
            stall      = out_valid && !out_ready;
            hold_pixel = out_pixel;
            hold_row   = out_row;
            hold_id    = out_id;
            hold_last  = out_last;
            if (out_valid && out_ready) begin
                check_beat();
            end
            if (test_end) begin
                finish_test();
            end
        end
    end

endmodule : dual_cam_line_checker

`default_nettype wire

/* bench/dual_cam_line_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cam_line_config.svh"

module dual_cam_line_tb;

    import cam_line_pkg::*;

    localparam int H_ACT        = 8;
    localparam int V_ACT        = 16;
    localparam int LINE_LEN     = H_ACT + 3;    // Active pixels plus blank gap
    localparam int FRAME_LEN    = V_ACT * LINE_LEN;
    localparam int SKIP_COL     = 3;
    localparam int QUIET_CYCLES = 40;
    localparam int NUM_TESTS    = 5;
    localparam int MAX_CYCLES   = NUM_TESTS * 200;

    typedef struct packed {
        logic [3:0] trig_cnt;
        logic       rand_ready;
        logic       skip_col;
        logic       exp_err;
    } test_row_t;

    // ~~~~~~~~~~~~~~~~~~~~
    // Stimulus table
    // ~~~~~~~~~~~~~~~~~~~~
    localparam test_row_t TESTS [NUM_TESTS] = '{
        '{4'd1, 1'b0, 1'b0, 1'b0},    // One pair with the sink always ready
        '{4'd1, 1'b1, 1'b0, 1'b0},    // Random back-pressure
        '{4'd2, 1'b1, 1'b0, 1'b0},    // Second trigger mid-cycle
        '{4'd1, 1'b0, 1'b1, 1'b1},    // Camera 1 drops a column number
        '{4'd1, 1'b1, 1'b0, 1'b1}     // Error still set
    };

    logic        rclk;
    logic        rstn;
    logic        trig_in;
    logic        out_ready;
    cam_pack_t   cam1_pack;
    cam_pack_t   cam2_pack;
    logic        out_valid;
    logic [15:0] out_pixel;
    logic [10:0] out_row;
    cam_id_t     out_id;
    logic        out_last;
    logic        error;

    logic        rand_ready;
    logic        skip_col;
    integer      seed;
    int          gen_pos;

    logic        test_start;
    logic        test_end;
    int          test_num;
    int          exp_lines;
    logic        exp_err;
    int          lines_seen;
    int          beats_seen;
    int          tests_run;
    int          tests_failed;
    int          fail_cnt;

    dual_cam_line_top #(.H_ACT(H_ACT), .V_ACT(V_ACT)) dut (
        .rclk     (rclk),
        .rstn     (rstn),
        .trig_in  (trig_in),
        .cam1_pack(cam1_pack),
        .cam2_pack(cam2_pack),
        .out_ready(out_ready),
        .out_valid(out_valid),
        .out_pixel(out_pixel),
        .out_row  (out_row),
        .out_id   (out_id),
        .out_last (out_last),
        .error    (error)
    );

    dual_cam_line_checker #(.H_ACT(H_ACT)) u_checker (
        .rclk        (rclk),
        .rstn        (rstn),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_pixel   (out_pixel),
        .out_row     (out_row),
        .out_id      (out_id),
        .out_last    (out_last),
        .error       (error),
        .test_start  (test_start),
        .test_end    (test_end),
        .test_num    (test_num),
        .exp_lines   (exp_lines),
        .exp_err     (exp_err),
        .lines_seen  (lines_seen),
        .beats_seen  (beats_seen),
        .tests_run   (tests_run),
        .tests_failed(tests_failed),
        .fail_cnt    (fail_cnt)
    );

    initial begin
        rclk = 1'b0;
        forever #50 rclk = ~rclk;
    end

    // One packet slot of a free-running camera
    function automatic cam_pack_t make_pack(input logic [3:0] cam_num, input int pos,
                                            input logic skip);
        cam_pack_t p;
        int        row_no;
        int        col_no;
        row_no = pos / LINE_LEN;
        col_no = pos % LINE_LEN;
        p      = '0;
        if (col_no < H_ACT) begin
            p.vld   = 1'b1;
            p.row   = 11'(row_no);
            p.col   = (skip && col_no >= SKIP_COL) ? 11'(col_no + 1) : 11'(col_no);
            p.pixel = {cam_num, 4'(row_no), 8'(col_no)};    // Pixel keeps true position
        end
        return p;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~
    // Camera and sink drivers
    // ~~~~~~~~~~~~~~~~~~~~
    initial begin
        logic skip_now;
        gen_pos   = 0;
        cam1_pack = '0;
        cam2_pack = '0;
        forever begin
            @(posedge rclk);
            skip_now = skip_col;
            #1;
            cam1_pack = make_pack(4'd1, gen_pos, skip_now);
            cam2_pack = make_pack(4'd2, (gen_pos + 5) % FRAME_LEN, 1'b0);   // Offset phase
            gen_pos   = (gen_pos + 1) % FRAME_LEN;
        end
    end

    initial begin
        logic rand_now;
        int   rnd;
        seed      = 32'h3c86d303;
        out_ready = 1'b0;
        forever begin
            @(posedge rclk);
            rand_now = rand_ready;
            #1;
            if (rand_now) begin
                rnd       = $random(seed);
                out_ready = rnd[0];
            end else begin
                out_ready = 1'b1;
            end
        end
    end

    task automatic pulse_trigger();
        trig_in = 1'b1;
        @(posedge rclk);
        #1;
        trig_in = 1'b0;
    endtask

    task automatic wait_beats(input int n);
        do begin
            @(posedge rclk);
            #1;
        end while (beats_seen < n);
    endtask

    task automatic wait_lines(input int n);
        do begin
            @(posedge rclk);
            #1;
        end while (lines_seen < n);
    endtask

    task automatic run_test(input int idx);
        test_row_t cfg;
        int        k;
        cfg        = TESTS[idx];
        test_num   = idx;
        exp_lines  = 2 * int'(cfg.trig_cnt);
        exp_err    = cfg.exp_err;
        rand_ready = cfg.rand_ready;
        skip_col   = cfg.skip_col;
        test_start = 1'b1;
        @(posedge rclk);
        #1;
        test_start = 1'b0;
        for (k = 0; k < int'(cfg.trig_cnt); k++) begin
            if (k > 0) begin
                wait_beats((k - 1) * 2 * H_ACT + 3);    // Cycle still running
            end
            pulse_trigger();
        end
        wait_lines(exp_lines);
        repeat (QUIET_CYCLES) @(posedge rclk);    // Room for stray lines to show
        #1;
        test_end = 1'b1;
        @(posedge rclk);
        #1;
        test_end = 1'b0;
        skip_col = 1'b0;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Main sequence
    // ~~~~~~~~~~~~~~~~~~~~
    initial begin
        int t;
        rstn       = 1'b0;
        trig_in    = 1'b0;
        rand_ready = 1'b0;
        skip_col   = 1'b0;
        test_start = 1'b0;
        test_end   = 1'b0;
        test_num   = 0;
        exp_lines  = 0;
        exp_err    = 1'b0;
        repeat (3) @(posedge rclk);
        #1;
        rstn = 1'b1;
        for (t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        @(posedge rclk);
        #1;
        $display("tests run %0d, tests failed %0d, failed checks %0d",
                 tests_run, tests_failed, fail_cnt);
        if ((tests_failed == 0) && (fail_cnt == 0) && (tests_run == NUM_TESTS)) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (MAX_CYCLES) @(posedge rclk);
        $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
        $display("** FAIL **");
        $finish;
    end

endmodule : dual_cam_line_tb

`default_nettype wire

/* dual_cam_line_top.f */
+incdir+hw
hw/cam_line_pkg.sv
hw/line_buffer.sv
hw/line_swap_buffer.sv
hw/cam_line_streamer.sv
hw/dual_cam_line_top.sv
bench/dual_cam_line_asserts.sv
bench/dual_cam_line_checker.sv
bench/dual_cam_line_tb.sv

/* hw/cam_line_config.svh */
`ifndef CAM_LINE_CONFIG_SVH
`define CAM_LINE_CONFIG_SVH

// ~~~~~~~~~~~~~~~~~~~~
// Sensor geometry
// ~~~~~~~~~~~~~~~~~~~~
`define CAM_H_ACT 1280
`define CAM_V_ACT 720

// ~~~~~~~~~~~~~~~~~~~~
// Camera tags, one-hot
// ~~~~~~~~~~~~~~~~~~~~
`define CAM1_ID 5'b10000
`define CAM2_ID 5'b01000

`endif

/* hw/cam_line_pkg.sv */
`default_nettype none

package cam_line_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // Camera stream types
    // ~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        logic        vld;    // Packet present
        logic [10:0] row;
        logic [10:0] col;
        logic [15:0] pixel;
    } cam_pack_t;

    // One-hot tag, codes in the config header
    typedef logic [4:0] cam_id_t;

    typedef enum logic [2:0] {
        idle      = 3'd0,
        trig_cam1 = 3'd1,
        wait_cam1 = 3'd2,
        gap       = 3'd3,
        trig_cam2 = 3'd4,
        wait_cam2 = 3'd5
    } swap_state_t;

endpackage : cam_line_pkg

`default_nettype wire

/* hw/cam_line_streamer.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cam_line_config.svh"

module cam_line_streamer #(
    parameter int H_ACT = `CAM_H_ACT
) (
    input  wire                        rclk,
    input  wire                        rstn,
    input  wire                        aquire,
    input  wire [15:0]                 cam_data,
    input  wire [10:0]                 cam_row,
    input  wire cam_line_pkg::cam_id_t cam_id,
    input  wire                        out_ready,
    output logic                       read_en,
    output logic                       out_valid,
    output logic [15:0]                out_pixel,
    output logic [10:0]                out_row,
    output cam_line_pkg::cam_id_t      out_id,
    output logic                       out_last
);

    import cam_line_pkg::*;

    localparam int AW = (H_ACT > 1) ? $clog2(H_ACT) : 1;
    localparam logic [AW-1:0] LAST_IDX = AW'(H_ACT - 1);

    logic [15:0]   ent_pixel [2];
    logic [10:0]   ent_row   [2];
    cam_id_t       ent_id    [2];
    logic          ent_last  [2];
    logic          wr_idx;
    logic          rd_idx;
    logic [1:0]    held_cnt;
    logic          rd_pend;    // Read issued, data arrives next cycle
    logic [AW-1:0] pix_idx;
    logic          pop;

    assign pop = out_valid && out_ready;

    // Held plus in flight, minus the beat leaving now, must stay below two
    assign read_en = aquire && ((3'(held_cnt) + 3'(rd_pend)) < (3'd2 + 3'(pop)));

    assign out_valid = (held_cnt != 2'd0);
    assign out_pixel = ent_pixel[rd_idx];
    assign out_row   = ent_row[rd_idx];
    assign out_id    = ent_id[rd_idx];
    assign out_last  = ent_last[rd_idx];

    // ~~~~~~~~~~~~~~~~~~~~
    // Skid buffer pointers
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge rclk or negedge rstn) begin
        if (!rstn) begin
            rd_pend  <= 1'b0;
            held_cnt <= 2'd0;
            wr_idx   <= 1'b0;
            rd_idx   <= 1'b0;
            pix_idx  <= '0;
        end else begin
            rd_pend  <= read_en;
            held_cnt <= held_cnt + 2'(rd_pend) - 2'(pop);
            if (rd_pend) begin
                wr_idx  <= !wr_idx;
                pix_idx <= (pix_idx == LAST_IDX) ? '0 : pix_idx + 1'b1;
            end
            if (pop) begin
                rd_idx <= !rd_idx;
            end
        end
    end

    always_ff @(posedge rclk) begin
        if (rd_pend) begin
            ent_pixel[wr_idx] <= cam_data;
            ent_row[wr_idx]   <= cam_row;
            ent_id[wr_idx]    <= cam_id;
            ent_last[wr_idx]  <= (pix_idx == LAST_IDX);  // Last pixel of line
        end
    end

endmodule : cam_line_streamer

`default_nettype wire

/* hw/dual_cam_line_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cam_line_config.svh"

module dual_cam_line_top #(
    parameter int H_ACT = `CAM_H_ACT,
    parameter int V_ACT = `CAM_V_ACT
) (
    input  wire                          rclk,
    input  wire                          rstn,
    input  wire                          trig_in,
    input  wire cam_line_pkg::cam_pack_t cam1_pack,
    input  wire cam_line_pkg::cam_pack_t cam2_pack,
    input  wire                          out_ready,
    output logic                         out_valid,
    output logic [15:0]                  out_pixel,
    output logic [10:0]                  out_row,
    output cam_line_pkg::cam_id_t        out_id,
    output logic                         out_last,
    output logic                         error
);

    logic                  aquire;
    logic                  read_en;
    logic [15:0]           cam_data;
    logic [10:0]           cam_row;
    cam_line_pkg::cam_id_t cam_id;

    line_swap_buffer #(.H_ACT(H_ACT), .V_ACT(V_ACT)) u_swap (
        .rclk     (rclk),
        .rstn     (rstn),
        .trig     (trig_in),
        .cam1_pack(cam1_pack),
        .cam2_pack(cam2_pack),
        .read_en  (read_en),
        .aquire   (aquire),
        .cam_data (cam_data),
        .cam_row  (cam_row),
        .cam_id   (cam_id),
        .error    (error)
    );

    cam_line_streamer #(.H_ACT(H_ACT)) u_streamer (
        .rclk     (rclk),
        .rstn     (rstn),
        .aquire   (aquire),
        .cam_data (cam_data),
        .cam_row  (cam_row),
        .cam_id   (cam_id),
        .out_ready(out_ready),
        .read_en  (read_en),
        .out_valid(out_valid),
        .out_pixel(out_pixel),
        .out_row  (out_row),
        .out_id   (out_id),
        .out_last (out_last)
    );

endmodule : dual_cam_line_top

`default_nettype wire

/* hw/line_buffer.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cam_line_config.svh"

module line_buffer #(
    parameter int H_ACT = `CAM_H_ACT,
    parameter int V_ACT = `CAM_V_ACT
) (
    input  wire                       rclk,
    input  wire                       rstn,
    input  wire                       trig,
    input  wire cam_line_pkg::cam_pack_t cam_pack,
    input  wire                       read_en,
    output logic                      aquire,
    output logic [15:0]               cam_data,
    output logic [10:0]               cam_row,
    output logic                      busy,
    output logic                      error
);

    localparam int AW = (H_ACT > 1) ? $clog2(H_ACT) : 1;
    localparam logic [AW-1:0] LAST_IDX = AW'(H_ACT - 1);

    typedef enum logic [1:0] {
        lb_idle,
        lb_arm,
        lb_cap,
        lb_read
    } lb_state_t;

    lb_state_t     state;
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [10:0]   last_col;
    logic [15:0]   line_mem [H_ACT];
    logic          start_ok;
    logic          wr_en;
    logic          rd_fire;

    // First packet of a line inside the active frame
    assign start_ok = cam_pack.vld && (cam_pack.col == 11'd0)
                      && (int'(cam_pack.row) < V_ACT);

    assign wr_en   = ((state == lb_arm) && start_ok) || ((state == lb_cap) && cam_pack.vld);
    assign aquire  = (state == lb_read);
    assign rd_fire = aquire && read_en;   // Reads outside read-out dropped
    assign busy    = (state != lb_idle);

    // ~~~~~~~~~~~~~~~~~~~~
    // Capture / read-out control
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge rclk or negedge rstn) begin
        if (!rstn) begin
            state    <= lb_idle;
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            last_col <= '0;
            error    <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr   <= (wr_ptr == LAST_IDX) ? '0 : wr_ptr + 1'b1;
                last_col <= cam_pack.col;
            end
            if (rd_fire) begin
                rd_ptr <= (rd_ptr == LAST_IDX) ? '0 : rd_ptr + 1'b1;
            end
            case (state)
                lb_idle: begin
                    if (trig) begin
                        state <= lb_arm;
                    end
                end
                lb_arm: begin
                    if (start_ok) begin
                        state <= (wr_ptr == LAST_IDX) ? lb_read : lb_cap;
                    end
                end
                lb_cap: begin
                    if (cam_pack.vld) begin
                        if (cam_pack.col != last_col + 11'd1) begin
                            error <= 1'b1;    // Sticky, line still completes
                        end
                        if (wr_ptr == LAST_IDX) begin
                            state <= lb_read;
                        end
                    end
                end
                lb_read: begin
                    if (rd_fire && (rd_ptr == LAST_IDX)) begin
                        state <= lb_idle;
                    end
                end
                default: begin
                    state <= lb_idle;
                end
            endcase
        end
    end

    // Line storage and read port
    always_ff @(posedge rclk) begin
        if (wr_en) begin
            line_mem[wr_ptr] <= cam_pack.pixel;
        end
        if (rd_fire) begin
            cam_data <= line_mem[rd_ptr];
        end
        if ((state == lb_arm) && start_ok) begin
            cam_row <= cam_pack.row;
        end
    end

endmodule : line_buffer

`default_nettype wire

/* hw/line_swap_buffer.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cam_line_config.svh"

module line_swap_buffer #(
    parameter int H_ACT = `CAM_H_ACT,
    parameter int V_ACT = `CAM_V_ACT
) (
    input  wire                          rclk,
    input  wire                          rstn,
    input  wire                          trig,
    input  wire cam_line_pkg::cam_pack_t cam1_pack,
    input  wire cam_line_pkg::cam_pack_t cam2_pack,
    input  wire                          read_en,
    output logic                         aquire,
    output logic [15:0]                  cam_data,
    output logic [10:0]                  cam_row,
    output cam_line_pkg::cam_id_t        cam_id,
    output logic                         error
);

    import cam_line_pkg::*;

    swap_state_t state;
    logic        trig_q;
    logic        cam_no;      // 0 selects camera 1

    logic        cam1_trig;
    logic        cam1_aquire;
    logic [15:0] cam1_data;
    logic [10:0] cam1_row;
    logic        cam1_busy;
    logic        cam1_err;

    logic        cam2_trig;
    logic        cam2_aquire;
    logic [15:0] cam2_data;
    logic [10:0] cam2_row;
    logic        cam2_busy;
    logic        cam2_err;

    line_buffer #(.H_ACT(H_ACT), .V_ACT(V_ACT)) u_line_buffer_1 (
        .rclk    (rclk),
        .rstn    (rstn),
        .trig    (cam1_trig),
        .cam_pack(cam1_pack),
        .read_en (read_en && !cam_no),
        .aquire  (cam1_aquire),
        .cam_data(cam1_data),
        .cam_row (cam1_row),
        .busy    (cam1_busy),
        .error   (cam1_err)
    );

    line_buffer #(.H_ACT(H_ACT), .V_ACT(V_ACT)) u_line_buffer_2 (
        .rclk    (rclk),
        .rstn    (rstn),
        .trig    (cam2_trig),
        .cam_pack(cam2_pack),
        .read_en (read_en && cam_no),
        .aquire  (cam2_aquire),
        .cam_data(cam2_data),
        .cam_row (cam2_row),
        .busy    (cam2_busy),
        .error   (cam2_err)
    );

    // ~~~~~~~~~~~~~~~~~~~~
    // Read side mux
    // ~~~~~~~~~~~~~~~~~~~~
    assign aquire   = cam_no ? cam2_aquire : cam1_aquire;
    assign cam_data = cam_no ? cam2_data : cam1_data;
    assign cam_row  = cam_no ? cam2_row : cam1_row;
    assign cam_id   = cam_no ? `CAM2_ID : `CAM1_ID;
    assign error    = cam1_err || cam2_err;

    // Trigger seen while a cycle runs waits here
    always_ff @(posedge rclk or negedge rstn) begin
        if (!rstn) begin
            trig_q <= 1'b0;
        end else begin
            trig_q <= (trig_q || trig) && (state != idle);
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Swap FSM
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge rclk or negedge rstn) begin
        if (!rstn) begin
            state     <= idle;
            cam_no    <= 1'b0;
            cam1_trig <= 1'b0;
            cam2_trig <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (trig || trig_q) begin
                        cam1_trig <= 1'b1;
                        state     <= trig_cam1;
                    end
                end
                trig_cam1: begin
                    if (cam1_busy) begin
                        cam1_trig <= 1'b0;
                        state     <= wait_cam1;
                    end
                end
                wait_cam1: begin
                    if (!cam1_busy) begin
                        cam_no <= 1'b1;
                        state  <= gap;
                    end
                end
                gap: begin
                    if (!cam1_busy && !cam2_busy) begin
                        cam2_trig <= 1'b1;
                        state     <= trig_cam2;
                    end
                end
                trig_cam2: begin
                    if (cam2_busy) begin
                        cam2_trig <= 1'b0;
                        state     <= wait_cam2;
                    end
                end
                wait_cam2: begin
                    if (!cam2_busy) begin
                        cam_no <= 1'b0;   // Back to camera 1
                        state  <= idle;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

endmodule : line_swap_buffer

`default_nettype wire
